// ==== sim/arb_cases.txt ====
// one hex word per case: digit 1 drop flag, digits 2-3 request mask,
// digit 4 expected winner id; rotation count starts at 0, one step per case.
0010 // single requesters
0807
0104
0083
0021
0406
0205
0042
0ff0 // full mask, one full rotation
0ff1
0ff2
0ff3
0ff4
0ff5
0ff6
0ff7
0a50 // mixed masks
0c07
00c2
0305
0817
00f1
05a6
0666
1904 // requests dropped right after the grant
13c3
0f06
1183
0030
1ff5
0245
1426

// ==== files.f ====
common/arb_pkg.sv
arbiter/rotating_selector.sv
arbiter/arb_fsm.sv
arbiter/burst_timer.sv
verilog/bus_mux.sv
verilog/bus_arbiter_top.sv
sim/tb_clock.sv
sim/bus_arbiter_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bus arbiter testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module bus_arbiter_tb \
    -Mdir obj_dir \
    -o bus_arbiter_sim

sim_output="$(./obj_dir/bus_arbiter_sim 2>&1)" || {
    echo "$sim_output"
    exit 1
}
echo "$sim_output"

if grep -qF '*** PASSED ***' <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

// ==== sim/bus_arbiter_tb.sv ====
`timescale 1ns/1ps

module bus_arbiter_tb import arb_pkg::*; ();

    localparam int reset_cycles = 16;
    localparam int case_cycles  = 20; // watchdog budget for one case.
    localparam int max_cases    = 64;
    localparam int grant_wait   = 8;

    logic                           clock;
    logic                           reset;
    logic [num_req-1:0]             req;
    logic [num_req-1:0][data_w-1:0] req_data;
    logic [num_req-1:0]             gnt;
    logic                           bus_valid;
    logic [data_w-1:0]              bus_data;
    logic [req_id_w-1:0]            bus_source;

    // one case per word, drop flag in [12], mask in [11:4], id in [2:0].
    logic [15:0]       case_mem [max_cases];
    int                num_cases;
    int                error_count;
    int                failed_cases;
    logic [15:0]       lfsr_state;
    logic [data_w-1:0] word_queue [$]; // winner words still waiting for their bus beat.

    tb_clock #(
        .reset_cycles (reset_cycles)
    ) tb_clock_i (
        .clock (clock),
        .reset (reset)
    );

    bus_arbiter_top bus_arbiter_top_i (
        .clock      (clock),
        .reset      (reset),
        .req        (req),
        .req_data   (req_data),
        .gnt        (gnt),
        .bus_valid  (bus_valid),
        .bus_data   (bus_data),
        .bus_source (bus_source)
    );

    // taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_word(output logic [data_w-1:0] w);
        for (int k = 0; k < data_w; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[k]       = lfsr_state[0];
        end
    endtask

    task automatic check_id(input string name, input logic [req_id_w-1:0] got,
                            input logic [req_id_w-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_grant(input string name, input logic [num_req-1:0] got,
                               input logic [num_req-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // every requester gets a new word, the winner's copy is kept for the bus check.
    task automatic drive_fresh_data(input logic [req_id_w-1:0] winner);
        logic [data_w-1:0] word;
        for (int n = 0; n < num_req; n++) begin
            draw_word(word);
            req_data[n] = word;
        end
        word_queue.push_back(req_data[winner]);
    endtask

    task automatic check_beat(input logic [req_id_w-1:0] exp_id);
        check_flag("bus_valid", bus_valid, 1'b1);
        check_word("bus_data", bus_data, word_queue.pop_front());
        check_id("bus_source", bus_source, exp_id);
    endtask

    task automatic run_case(input int idx, input logic [num_req-1:0] mask,
                            input logic [req_id_w-1:0] exp_id, input logic drop,
                            output logic [num_req-1:0] seen_gnt);
        logic [num_req-1:0] exp_gnt;
        int                 waited;
        int                 errors_before;
        exp_gnt       = num_req'(1) << exp_id;
        errors_before = error_count;
        seen_gnt      = '0;
        word_queue.delete();
        req    = mask;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (gnt == '0 && waited < grant_wait);
        if (gnt == '0) begin
            $display("case %0d: no grant within %0d cycles of the request", idx, grant_wait);
            error_count++;
            failed_cases++;
            req = '0;
            return;
        end
        seen_gnt = gnt;
        for (int beat = 0; beat < burst_beats; beat++) begin
            check_grant("gnt", gnt, exp_gnt);
            if (beat == 0) begin
                check_flag("bus_valid", bus_valid, 1'b0);
                if (drop) req = '0; // the burst has to finish anyway.
            end else begin
                check_beat(exp_id);
            end
            drive_fresh_data(exp_id);
            @(negedge clock);
        end
        check_grant("gnt", gnt, '0); // grant ends after burst_beats cycles.
        check_beat(exp_id);
        req = '0;
        @(negedge clock);
        check_grant("gnt", gnt, '0);
        check_flag("bus_valid", bus_valid, 1'b0);
        if (error_count == errors_before) begin
            $display("case %0d mask %b id %0d drop %b: ok", idx, mask, exp_id, drop);
        end else begin
            $display("case %0d mask %b id %0d drop %b: %0d errors", idx, mask, exp_id,
                     drop, error_count - errors_before);
            failed_cases++;
        end
    endtask

    initial begin
        logic [num_req-1:0] seen;
        logic [num_req-1:0] full_seen;
        int                 full_run;
        int                 errors_before;
        req          = '0;
        req_data     = '0;
        error_count  = 0;
        failed_cases = 0;
        num_cases    = 0;
        full_seen    = '0;
        full_run     = 0;
        lfsr_state   = 16'd37979;
        for (int i = 0; i < max_cases; i++) begin
            case_mem[i] = '1; // all ones marks the end of the list.
        end
        $readmemh("sim/arb_cases.txt", case_mem);
        while (num_cases < max_cases && case_mem[num_cases] != 16'hffff) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("no cases could be read from sim/arb_cases.txt");
            error_count++;
        end

        errors_before = error_count;
        repeat (reset_cycles + 3) begin
            @(negedge clock);
            check_grant("gnt", gnt, '0);
            check_flag("bus_valid", bus_valid, 1'b0);
        end
        $display("reset: %0d errors", error_count - errors_before);

        for (int i = 0; i < num_cases; i++) begin
            run_case(i, case_mem[i][11:4], case_mem[i][2:0], case_mem[i][12], seen);
            if (case_mem[i][11:4] == '1) begin
                full_seen |= seen;
                full_run++;
                if (full_run == num_req) begin
                    errors_before = error_count;
                    check_grant("rotation grants", full_seen, '1);
                    $display("rotation over cases %0d to %0d: %0d errors", i - num_req + 1, i,
                             error_count - errors_before);
                    full_run  = 0;
                    full_seen = '0;
                end
            end else begin
                full_run  = 0;
                full_seen = '0;
            end
        end

        $display("%0d cases, %0d failed, %0d check errors", num_cases, failed_cases,
                 error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        int limit_cycles;
        #1;
        limit_cycles = num_cases * case_cycles + reset_cycles;
        repeat (limit_cycles) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int reset_cycles = 16
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock; // 10 ns period.
    end

    // reset is released on a falling edge, like the other DUT inputs.
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// ==== verilog/bus_arbiter_top.sv ====
`timescale 1ns/1ps

module bus_arbiter_top import arb_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [num_req-1:0]             req,
    input  logic [num_req-1:0][data_w-1:0] req_data,
    output logic [num_req-1:0]             gnt,
    output logic                           bus_valid,
    output logic [data_w-1:0]              bus_data,
    output logic [req_id_w-1:0]            bus_source
);

    logic [req_id_w-1:0] rot_count;
    logic [num_req-1:0]  sel_onehot;
    logic [req_id_w-1:0] sel_id;
    logic                any_req;
    logic                start;
    logic                last_beat;
    logic [req_id_w-1:0] grant_id;
    logic                busy;

    // combinational pick, steered by the rotation count.
    rotating_selector rotating_selector_i (
        .req        (req),
        .rot_count  (rot_count),
        .sel_onehot (sel_onehot),
        .sel_id     (sel_id),
        .any_req    (any_req)
    );

    arb_fsm arb_fsm_i (
        .clock      (clock),
        .reset      (reset),
        .any_req    (any_req),
        .sel_onehot (sel_onehot),
        .sel_id     (sel_id),
        .last_beat  (last_beat),
        .rot_count  (rot_count),
        .start      (start),
        .gnt        (gnt),
        .grant_id   (grant_id),
        .busy       (busy)
    );

    burst_timer burst_timer_i (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .last_beat (last_beat)
    );

    // bus beats trail the gnt cycles by one clock.
    bus_mux bus_mux_i (
        .clock      (clock),
        .reset      (reset),
        .busy       (busy),
        .grant_id   (grant_id),
        .req_data   (req_data),
        .bus_valid  (bus_valid),
        .bus_data   (bus_data),
        .bus_source (bus_source)
    );

endmodule

// ==== verilog/bus_mux.sv ====
`timescale 1ns/1ps

module bus_mux import arb_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           busy,
    input  logic [req_id_w-1:0]            grant_id,
    input  logic [num_req-1:0][data_w-1:0] req_data,
    output logic                           bus_valid,
    output logic [data_w-1:0]              bus_data,
    output logic [req_id_w-1:0]            bus_source
);

    // one beat per busy cycle, no back-pressure.
    always_ff @(posedge clock) begin
        if (reset) begin
            bus_valid <= 1'b0;
        end else begin
            bus_valid <= busy;
        end
    end

    // the granted requester's word and id, one cycle after its gnt cycle.
    always_ff @(posedge clock) begin
        bus_data   <= req_data[grant_id];
        bus_source <= grant_id;
    end

endmodule

// ==== arbiter/burst_timer.sv ====
`timescale 1ns/1ps

module burst_timer import arb_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic last_beat
);

    logic              active;
    logic [beat_w-1:0] beat_count;

    // beat_count is the index of the current gnt cycle.
    assign last_beat = active && (beat_count == beat_w'(burst_beats - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            active     <= 1'b0;
            beat_count <= '0;
        end else if (start) begin
            active     <= 1'b1; // first gnt cycle follows this edge.
            beat_count <= '0;
        end else if (last_beat) begin
            active     <= 1'b0;
            beat_count <= '0;
        end else if (active) begin
            beat_count <= beat_count + beat_w'(1);
        end
    end

    a_no_start_while_active: assert property (
        @(posedge clock) disable iff (reset)
        start |-> !active
    );

endmodule

// ==== arbiter/arb_fsm.sv ====
`timescale 1ns/1ps

module arb_fsm import arb_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                any_req,
    input  logic [num_req-1:0]  sel_onehot,
    input  logic [req_id_w-1:0] sel_id,
    input  logic                last_beat,
    output logic [req_id_w-1:0] rot_count,
    output logic                start,
    output logic [num_req-1:0]  gnt,
    output logic [req_id_w-1:0] grant_id,
    output logic                busy
);

    arb_state_t state;

    // a burst starts on the first idle cycle that sees a request.
    assign start = (state == idle) && any_req;
    assign busy  = (state == burst);

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= idle;
            gnt       <= '0;
            grant_id  <= '0;
            rot_count <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        gnt       <= sel_onehot;
                        grant_id  <= sel_id;
                        rot_count <= rot_count + req_id_w'(1); // winner used the old value.
                        state     <= burst;
                    end
                end
                burst: begin
                    // the grant is held until the timer flags the final beat.
                    if (last_beat) begin
                        gnt   <= '0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    a_gnt_onehot0: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(gnt)
    );

    // a grant without a burst, or a burst without a grant, means the
    // selector handed over an empty mask.
    a_gnt_in_burst: assert property (
        @(posedge clock) disable iff (reset)
        (gnt != '0) == (state == burst)
    );

    // every grant lasts exactly burst_beats cycles.
    a_burst_length: assert property (
        @(posedge clock) disable iff (reset)
        start |=> busy [*burst_beats] ##1 !busy
    );

endmodule

// ==== arbiter/rotating_selector.sv ====
`timescale 1ns/1ps

module rotating_selector import arb_pkg::*; (
    input  logic [num_req-1:0]  req,
    input  logic [req_id_w-1:0] rot_count,
    output logic [num_req-1:0]  sel_onehot,
    output logic [req_id_w-1:0] sel_id,
    output logic                any_req
);

    // request-present flags passed up the tree.
    logic [3:0] pair_req;
    logic [1:0] quad_req;

    // enables passed down the tree.
    logic [1:0] quad_en;
    logic [3:0] pair_en;

    // one two-input node. bit 1 is the upper input, bit 0 the lower one.
    // with pri high the upper input is preferred, otherwise the lower one.
    function automatic logic [1:0] node_pick(
        input logic [1:0] r,
        input logic       en,
        input logic       pri
    );
        logic [1:0] win;
        win[1] = en && r[1] && (pri || !r[0]);
        win[0] = en && r[0] && (!pri || !r[1]);
        return win;
    endfunction

    genvar i;

    generate
        for (i = 0; i < 4; i++) begin : g_pair_req
            assign pair_req[i] = req[2*i+1] | req[2*i];
        end
        for (i = 0; i < 2; i++) begin : g_quad_req
            assign quad_req[i] = pair_req[2*i+1] | pair_req[2*i];
        end
    endgenerate

    assign any_req = quad_req[1] | quad_req[0];

    // top node, upper half 7..4 against lower half 3..0.
    assign quad_en = node_pick(quad_req, 1'b1, rot_count[2]);

    generate
        for (i = 0; i < 2; i++) begin : g_quad_node
            assign pair_en[2*i+1:2*i] = node_pick(pair_req[2*i+1:2*i], quad_en[i], rot_count[1]);
        end
        for (i = 0; i < 4; i++) begin : g_leaf_node
            assign sel_onehot[2*i+1:2*i] = node_pick(req[2*i+1:2*i], pair_en[i], rot_count[0]);
        end
    endgenerate

    always_comb begin
        sel_id = '0;
        for (int n = 0; n < num_req; n++) begin
            if (sel_onehot[n]) sel_id = sel_id | req_id_w'(n); // at most one bit is set.
        end
    end

    // the enable chain must leave exactly one winner whenever anyone asks.
    always_comb begin
        assert final (!any_req || $onehot(sel_onehot));
    end

endmodule

// ==== common/arb_pkg.sv ====
package arb_pkg;

    // requester count and the width of an id that names one of them.
    localparam int num_req  = 8;
    localparam int req_id_w = 3;

    // width of one data word on a request port and on the bus.
    localparam int data_w = 16;

    // every grant lasts this many beats.
    localparam int burst_beats = 4;
    localparam int beat_w      = 2; // wide enough to count 0 .. burst_beats-1.

    typedef enum logic {
        idle  = 1'b0,
        burst = 1'b1
    } arb_state_t;

endpackage
